//--- list.f
rtl/glb_pkg.sv
rtl/glb_tile_cfg.sv
rtl/glb_store_dma.sv
rtl/glb_bank.sv
rtl/glb_load_dma.sv
rtl/glb_tile.sv
verification/glb_tile_tb.sv

//--- run.sh
#!/bin/sh
# build and run the global buffer tile testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module glb_tile_tb -o glb_tile_tb

./obj_dir/glb_tile_tb | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi

//--- verification/glb_tile_tb.sv
// testbench for the global buffer tile with a reference memory model of the bank
`default_nettype none

module glb_tile_tb
    import glb_pkg::*;
();

    // hard stop for a run whose DMA never finishes its block
    localparam int CYCLE_LIMIT = 3000;

    logic                      clk;
    logic                      reset;
    logic                      stall;
    logic                      cfg_wr_en;
    logic                      cfg_rd_en;
    logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
    cfg_word_t                 cfg_wr_data;
    cfg_word_t                 cfg_rd_data;
    strm_t                     stream_f2g;
    strm_t                     stream_g2f;
    logic                      strm_start_pulse;
    logic                      ld_start_pulse;
    logic [1:0]                interrupt_pulse;

    integer                seed;
    int                    cycle = 0;
    int                    errors = 0;
    int                    err_mark = 0;
    int                    checks = 0;
    int                    irq_cnt [2];
    int                    st_last;
    int                    ld_start;
    int                    ld_last;
    int                    cur_lat;
    bit                    first_out;
    bit                    frozen;
    string                 test_name;
    // every word the store dma should have written
    logic [DATA_WIDTH-1:0] ref_mem [2**BANK_ADDR_WIDTH];
    // words still due on stream_g2f
    logic [DATA_WIDTH-1:0] exp_q [$];

    glb_tile dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // cycle count and time base for latency and interrupt checks
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, a DMA never finished its block", cycle);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_value(input string what, input int expv, input int actv);
        assert (expv == actv) checks++;
        else begin
            $display("** Error %s, %s: expected %0h, actual %0h", test_name, what, expv, actv);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) checks++;
        else begin
            $display("%s went wrong: %s", test_name, what);
            errors++;
        end
    endtask

    task automatic end_test();
        $display("%s finished with %0d errors", test_name, errors - err_mark);
        err_mark = errors;
    endtask

    // header and control words built through the union fields
    function automatic cfg_word_t hdr_word(input logic [7:0] start, input logic [7:0] n);
        cfg_word_t w;
        w = '0;
        w.hdr.start_addr = start;
        w.hdr.num_words = n;
        return w;
    endfunction

    function automatic cfg_word_t ctrl_word(input bit st, input bit ld);
        cfg_word_t w;
        w = '0;
        w.ctrl.st_en = st;
        w.ctrl.ld_en = ld;
        return w;
    endfunction

    task automatic cfg_write(input logic [CFG_ADDR_WIDTH-1:0] addr, input cfg_word_t w);
        @(posedge clk);
        cfg_wr_en   <= 1'b1;
        cfg_addr    <= addr;
        cfg_wr_data <= w;
        @(posedge clk);
        cfg_wr_en <= 1'b0;
    endtask

    // read data is due the cycle after the strobe
    task automatic read_check(input logic [CFG_ADDR_WIDTH-1:0] addr, input cfg_word_t w);
        @(posedge clk);
        cfg_rd_en <= 1'b1;
        cfg_addr  <= addr;
        @(posedge clk);
        cfg_rd_en <= 1'b0;
        @(posedge clk);
        check_value($sformatf("register %0d", addr), w, cfg_rd_data);
    endtask

    // interrupt totals after a few quiet cycles
    task automatic check_irqs(input int st_exp, input int ld_exp);
        repeat (4) @(posedge clk);
        check_value("store interrupts", st_exp, irq_cnt[0]);
        check_value("load interrupts", ld_exp, irq_cnt[1]);
    endtask

    task automatic store_block(input logic [7:0] start, input int n, input bit en);
        int                    st0;
        int                    ld0;
        int                    i;
        logic [DATA_WIDTH-1:0] d;
        st0 = irq_cnt[0];
        ld0 = irq_cnt[1];
        cfg_write(CFG_ST_HDR_ADDR, hdr_word(start, n[7:0]));
        @(posedge clk);
        strm_start_pulse <= 1'b1;
        @(posedge clk);
        strm_start_pulse <= 1'b0;
        for (i = 0; i < n; i++) begin
            // random idle gap
            repeat ($random(seed) & 1) begin
                @(posedge clk);
                stream_f2g <= '0;
            end
            d = DATA_WIDTH'($random(seed));
            @(posedge clk);
            stream_f2g <= '{valid: 1'b1, data: d};
            if (en) begin
                ref_mem[start + i[7:0]] = d;
            end
        end
        // edge where the last word is taken
        @(posedge clk);
        st_last = cycle;
        stream_f2g <= '0;
        if (en) begin
            while (irq_cnt[0] == st0) @(posedge clk);
        end
        check_irqs(st0 + int'(en), ld0);
    endtask

    task automatic load_block(input logic [7:0] start, input int n, input int lat,
                              input int stall_at, input bit en);
        int st0;
        int ld0;
        int i;
        st0 = irq_cnt[0];
        ld0 = irq_cnt[1];
        cfg_write(CFG_LD_HDR_ADDR, hdr_word(start, n[7:0]));
        cfg_write(CFG_LAT_ADDR, cfg_word_t'({12'h000, lat[3:0]}));
        cur_lat = lat;
        first_out = 1'b1;
        for (i = 0; i < n && en; i++) begin
            exp_q.push_back(ref_mem[start + i[7:0]]);
        end
        @(posedge clk);
        ld_start_pulse <= 1'b1;
        @(posedge clk);
        ld_start = cycle;
        ld_start_pulse <= 1'b0;
        // freeze the tile for 6 cycles mid block
        if (stall_at > 0) begin
            repeat (stall_at) @(posedge clk);
            stall <= 1'b1;
            repeat (6) @(posedge clk);
            stall <= 1'b0;
        end
        if (en) begin
            while (irq_cnt[1] == ld0) @(posedge clk);
        end else begin
            repeat (n + 8) @(posedge clk);
        end
        check_irqs(st0, ld0 + int'(en));
        check_value("words never sent", 0, exp_q.size());
    endtask

    // output stream and interrupt monitor
    always @(posedge clk) begin
        if (!reset) begin
            if (frozen) begin
                check_true(!stream_g2f.valid, "output word while the tile is stalled");
            end
            if (stream_g2f.valid && exp_q.size() == 0) begin
                check_true(1'b0, "output word with no word expected");
            end else if (stream_g2f.valid) begin
                // first word is L+4 cycles after the sampled start
                if (first_out) begin
                    check_value("first word cycle", ld_start + cur_lat + 4, cycle);
                end
                first_out = 1'b0;
                check_value("load data", exp_q.pop_front(), stream_g2f.data);
                if (exp_q.size() == 0) begin
                    ld_last = cycle;
                end
            end
            if (interrupt_pulse[0]) begin
                check_value("store interrupt cycle", st_last + 2, cycle);
                irq_cnt[0]++;
            end
            if (interrupt_pulse[1]) begin
                check_value("load interrupt cycle", ld_last + 1, cycle);
                irq_cnt[1]++;
            end
        end
        frozen = stall;
    end

    initial begin
        int i;
        reset            = 1'b1;
        stall            = 1'b0;
        cfg_wr_en        = 1'b0;
        cfg_rd_en        = 1'b0;
        cfg_addr         = '0;
        cfg_wr_data      = '0;
        stream_f2g       = '0;
        strm_start_pulse = 1'b0;
        ld_start_pulse   = 1'b0;
        irq_cnt[0]       = 0;
        irq_cnt[1]       = 0;
        seed             = 32'h34aae7df;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        test_name = "register readback";
        for (i = 0; i < 4; i++) begin
            read_check(i[1:0], '0);
        end
        // unequal flags so a swapped pair shows up
        cfg_write(CFG_CTRL_ADDR, ctrl_word(1'b1, 1'b0));
        cfg_write(CFG_ST_HDR_ADDR, hdr_word(8'h10, 8'd20));
        cfg_write(CFG_LD_HDR_ADDR, hdr_word(8'h40, 8'd7));
        cfg_write(CFG_LAT_ADDR, cfg_word_t'(16'h0005));
        read_check(CFG_CTRL_ADDR, ctrl_word(1'b1, 1'b0));
        read_check(CFG_ST_HDR_ADDR, hdr_word(8'h10, 8'd20));
        read_check(CFG_LD_HDR_ADDR, hdr_word(8'h40, 8'd7));
        read_check(CFG_LAT_ADDR, cfg_word_t'(16'h0005));
        cfg_write(CFG_CTRL_ADDR, ctrl_word(1'b1, 1'b1));
        read_check(CFG_CTRL_ADDR, ctrl_word(1'b1, 1'b1));
        end_test();

        test_name = "store then load";
        store_block(8'h10, 20, 1'b1);
        load_block(8'h10, 20, 0, 0, 1'b1);
        end_test();

        test_name = "load latency";
        load_block(8'h10, 8, 0, 0, 1'b1);
        load_block(8'h14, 8, 5, 0, 1'b1);
        end_test();

        test_name = "interrupts";
        store_block(8'h80, 12, 1'b1);
        load_block(8'h80, 12, 3, 0, 1'b1);
        end_test();

        test_name = "stall";
        load_block(8'h10, 20, 2, 8, 1'b1);
        end_test();

        // idle dmas drop words and the bank keeps the earlier block
        test_name = "disabled dma";
        cfg_write(CFG_CTRL_ADDR, ctrl_word(1'b0, 1'b0));
        store_block(8'h10, 10, 1'b0);
        load_block(8'h10, 10, 0, 0, 1'b0);
        cfg_write(CFG_CTRL_ADDR, ctrl_word(1'b0, 1'b1));
        load_block(8'h10, 20, 1, 0, 1'b1);
        end_test();

        $display("checks passed %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/glb_tile.sv
// global buffer tile top with stall, start and interrupt edge registers
`default_nettype none

module glb_tile
    import glb_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  logic                      cfg_wr_en,
    input  logic                      cfg_rd_en,
    input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  cfg_word_t                 cfg_wr_data,
    output cfg_word_t                 cfg_rd_data,
    input  strm_t                     stream_f2g,
    output strm_t                     stream_g2f,
    input  logic                      strm_start_pulse,
    input  logic                      ld_start_pulse,
    output logic [1:0]                interrupt_pulse
);

    logic                  stall_d1;
    logic                  clk_en;
    logic                  strm_start_pulse_d1;
    logic                  ld_start_pulse_d1;
    logic [1:0]            interrupt_pulse_int;
    logic                  st_done_pulse;
    logic                  ld_done_pulse;
    dma_ctrl_t             ctrl;
    dma_header_t           st_hdr;
    dma_header_t           ld_hdr;
    logic [LAT_WIDTH-1:0]  ld_latency;
    bank_wr_t              bank_wr;
    bank_rd_t              bank_rd;
    logic [DATA_WIDTH-1:0] bank_rd_data;
    logic                  bank_rd_valid;

    // stall, starts and interrupts each take one register stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stall_d1            <= 1'b0;
            strm_start_pulse_d1 <= 1'b0;
            ld_start_pulse_d1   <= 1'b0;
            interrupt_pulse     <= '0;
        end else begin
            stall_d1            <= stall;
            strm_start_pulse_d1 <= strm_start_pulse;
            ld_start_pulse_d1   <= ld_start_pulse;
            interrupt_pulse     <= interrupt_pulse_int;
        end
    end

    assign clk_en = !stall_d1;
    // bit 0 store, bit 1 load
    assign interrupt_pulse_int = {ld_done_pulse, st_done_pulse};

    // register file runs without clock enable
    glb_tile_cfg glb_tile_cfg (
        .clk(clk), .reset(reset),
        .cfg_wr_en(cfg_wr_en), .cfg_rd_en(cfg_rd_en), .cfg_addr(cfg_addr),
        .cfg_wr_data(cfg_wr_data), .cfg_rd_data(cfg_rd_data),
        .ctrl(ctrl), .st_hdr(st_hdr), .ld_hdr(ld_hdr), .ld_latency(ld_latency)
    );

    glb_store_dma glb_store_dma (
        .clk(clk), .reset(reset), .clk_en(clk_en),
        .start_pulse(strm_start_pulse_d1), .enable(ctrl.st_en), .hdr(st_hdr),
        .strm_in(stream_f2g), .bank_wr(bank_wr), .done_pulse(st_done_pulse)
    );

    glb_bank glb_bank (
        .clk(clk), .reset(reset), .clk_en(clk_en),
        .bank_wr(bank_wr), .bank_rd(bank_rd),
        .rd_data(bank_rd_data), .rd_valid(bank_rd_valid)
    );

    glb_load_dma glb_load_dma (
        .clk(clk), .reset(reset), .clk_en(clk_en),
        .start_pulse(ld_start_pulse_d1), .enable(ctrl.ld_en), .hdr(ld_hdr),
        .latency(ld_latency), .bank_rd(bank_rd),
        .rd_data(bank_rd_data), .rd_valid(bank_rd_valid),
        .strm_out(stream_g2f), .done_pulse(ld_done_pulse)
    );

endmodule

`default_nettype wire

//--- rtl/glb_load_dma.sv
// load dma reading a bank block after a wait and streaming it out
`default_nettype none

module glb_load_dma
    import glb_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_en,
    input  logic                  start_pulse,
    input  logic                  enable,
    input  dma_header_t           hdr,
    input  logic [LAT_WIDTH-1:0]  latency,
    output bank_rd_t              bank_rd,
    input  logic [DATA_WIDTH-1:0] rd_data,
    input  logic                  rd_valid,
    output strm_t                 strm_out,
    output logic                  done_pulse
);

    logic                   busy;
    logic                   waiting;
    logic                   issuing;
    logic [LAT_WIDTH-1:0]   wait_cnt;
    logic [COUNT_WIDTH-1:0] issue_cnt;
    logic [COUNT_WIDTH-1:0] ret_cnt;
    dma_header_t            hdr_q;
    logic                   start_ok;
    logic                   ret_fire;
    logic                   ret_last;
    logic                   out_valid_q;
    logic [DATA_WIDTH-1:0]  out_data_q;
    logic                   done_q;

    assign start_ok = start_pulse && enable && !busy && (hdr.num_words != '0);
    assign ret_fire = busy && rd_valid;
    assign ret_last = (ret_cnt == hdr_q.num_words - 1'b1);

    // one read per enabled cycle, the bank ignores it under stall
    assign bank_rd.en   = issuing;
    assign bank_rd.addr = hdr_q.start_addr + issue_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy      <= 1'b0;
            waiting   <= 1'b0;
            issuing   <= 1'b0;
            wait_cnt  <= '0;
            issue_cnt <= '0;
            ret_cnt   <= '0;
            hdr_q     <= '0;
        end else if (start_ok) begin
            // zero latency goes straight to issuing
            busy      <= 1'b1;
            hdr_q     <= hdr;
            wait_cnt  <= latency;
            waiting   <= (latency != '0);
            issuing   <= (latency == '0);
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else if (clk_en) begin
            // latency countdown
            if (waiting) begin
                wait_cnt <= wait_cnt - 1'b1;
                if (wait_cnt == 1) begin
                    waiting <= 1'b0;
                    issuing <= 1'b1;
                end
            end
            // read issue
            if (issuing) begin
                issue_cnt <= issue_cnt + 1'b1;
                if (issue_cnt == hdr_q.num_words - 1'b1) begin
                    issuing <= 1'b0;
                end
            end
            // returned words, last one ends the block
            if (ret_fire) begin
                ret_cnt <= ret_cnt + 1'b1;
                if (ret_last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // output stage, a held word shows once the stall lifts
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid_q <= 1'b0;
            done_q      <= 1'b0;
        end else if (clk_en) begin
            out_valid_q <= ret_fire;
            done_q      <= ret_fire && ret_last;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en && ret_fire) begin
            out_data_q <= rd_data;
        end
    end

    // nothing leaves while frozen
    assign strm_out.valid = out_valid_q && clk_en;
    assign strm_out.data  = out_data_q;
    assign done_pulse     = done_q && clk_en;

endmodule

`default_nettype wire

//--- rtl/glb_bank.sv
// single-port sram bank with write priority and registered read
`default_nettype none

module glb_bank
    import glb_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clk_en,
    input  bank_wr_t              bank_wr,
    input  bank_rd_t              bank_rd,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic                  rd_valid
);

    logic [DATA_WIDTH-1:0] mem [2**BANK_ADDR_WIDTH];

    // one port, write wins, read output holds under stall
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (bank_wr.en) begin
                mem[bank_wr.addr] <= bank_wr.data;
            end else if (bank_rd.en) begin
                rd_data <= mem[bank_rd.addr];
            end
        end
    end

    // a read blocked by a write returns nothing
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else if (clk_en) begin
            rd_valid <= bank_rd.en && !bank_wr.en;
        end
    end

endmodule

`default_nettype wire

//--- rtl/glb_store_dma.sv
// store dma turning valid stream words into bank writes for one block
`default_nettype none

module glb_store_dma
    import glb_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_en,
    input  logic        start_pulse,
    input  logic        enable,
    input  dma_header_t hdr,
    input  strm_t       strm_in,
    output bank_wr_t    bank_wr,
    output logic        done_pulse
);

    logic                   busy;
    logic [COUNT_WIDTH-1:0] word_cnt;
    dma_header_t            hdr_q;
    logic                   wr_fire;
    logic                   last_word;

    // a word is taken only while busy and not stalled
    assign wr_fire   = busy && clk_en && strm_in.valid;
    assign last_word = (word_cnt == hdr_q.num_words - 1'b1);

    // same-cycle write at start plus count
    always_comb begin
        bank_wr.en   = wr_fire;
        bank_wr.addr = hdr_q.start_addr + word_cnt;
        bank_wr.data = strm_in.data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy       <= 1'b0;
            word_cnt   <= '0;
            hdr_q      <= '0;
            done_pulse <= 1'b0;
        end else begin
            // done is high for exactly one cycle
            done_pulse <= wr_fire && last_word;
            if (!busy) begin
                // header latched so host rewrites do not disturb the block
                if (start_pulse && enable && (hdr.num_words != '0)) begin
                    busy     <= 1'b1;
                    word_cnt <= '0;
                    hdr_q    <= hdr;
                end
            end else if (wr_fire) begin
                word_cnt <= word_cnt + 1'b1;
                if (last_word) begin
                    busy <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/glb_tile_cfg.sv
// configuration controller holding the dma headers, enables and load latency
`default_nettype none

module glb_tile_cfg
    import glb_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cfg_wr_en,
    input  logic                      cfg_rd_en,
    input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  cfg_word_t                 cfg_wr_data,
    output cfg_word_t                 cfg_rd_data,
    output dma_ctrl_t                 ctrl,
    output dma_header_t               st_hdr,
    output dma_header_t               ld_hdr,
    output logic [LAT_WIDTH-1:0]      ld_latency
);

    // only the two enable flags are kept from register 0
    logic                 st_en_q;
    logic                 ld_en_q;
    dma_header_t          st_hdr_q;
    dma_header_t          ld_hdr_q;
    logic [LAT_WIDTH-1:0] lat_q;
    cfg_word_t            rd_word;

    // host writes, decoded through the union by address
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            st_en_q  <= 1'b0;
            ld_en_q  <= 1'b0;
            st_hdr_q <= '0;
            ld_hdr_q <= '0;
            lat_q    <= '0;
        end else if (cfg_wr_en) begin
            case (cfg_addr)
                CFG_CTRL_ADDR: begin
                    st_en_q <= cfg_wr_data.ctrl.st_en;
                    ld_en_q <= cfg_wr_data.ctrl.ld_en;
                end
                CFG_ST_HDR_ADDR: st_hdr_q <= cfg_wr_data.hdr;
                CFG_LD_HDR_ADDR: ld_hdr_q <= cfg_wr_data.hdr;
                // latency sits in the low bits of the raw word
                CFG_LAT_ADDR: lat_q <= cfg_wr_data[LAT_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // readback mux, unused bits stay zero
    always_comb begin
        rd_word = '0;
        case (cfg_addr)
            CFG_CTRL_ADDR: begin
                rd_word.ctrl.st_en = st_en_q;
                rd_word.ctrl.ld_en = ld_en_q;
            end
            CFG_ST_HDR_ADDR: rd_word.hdr = st_hdr_q;
            CFG_LD_HDR_ADDR: rd_word.hdr = ld_hdr_q;
            CFG_LAT_ADDR: rd_word[LAT_WIDTH-1:0] = lat_q;
            default: ;
        endcase
    end

    // read data lands the cycle after the strobe, then holds
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_rd_data <= '0;
        end else if (cfg_rd_en) begin
            cfg_rd_data <= rd_word;
        end
    end

    assign ctrl       = '{st_en: st_en_q, ld_en: ld_en_q, reserved: '0};
    assign st_hdr     = st_hdr_q;
    assign ld_hdr     = ld_hdr_q;
    assign ld_latency = lat_q;

endmodule

`default_nettype wire

//--- rtl/glb_pkg.sv
// global buffer tile package with widths, register map and bus structs
`default_nettype none

package glb_pkg;

    // stream and bank word
    localparam int DATA_WIDTH = 16;
    // 256-word bank
    localparam int BANK_ADDR_WIDTH = 8;
    // transfer length field
    localparam int COUNT_WIDTH = 8;
    // load wait field in register 3
    localparam int LAT_WIDTH = 4;

    // configuration port
    localparam int CFG_ADDR_WIDTH = 2;
    localparam int CFG_DATA_WIDTH = 16;

    // register map
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_CTRL_ADDR   = 2'd0;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_ST_HDR_ADDR = 2'd1;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_LD_HDR_ADDR = 2'd2;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_LAT_ADDR    = 2'd3;

    // dma block descriptor, num_words of 0 means no transfer
    typedef struct packed {
        logic [BANK_ADDR_WIDTH-1:0] start_addr;
        logic [COUNT_WIDTH-1:0]     num_words;
    } dma_header_t;

    // enable flags in register 0
    typedef struct packed {
        logic                      st_en;
        logic                      ld_en;
        logic [CFG_DATA_WIDTH-3:0] reserved;
    } dma_ctrl_t;

    // one config word, read as header or control by address
    typedef union packed {
        dma_header_t hdr;
        dma_ctrl_t   ctrl;
    } cfg_word_t;

    // store dma to bank
    typedef struct packed {
        logic                       en;
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]      data;
    } bank_wr_t;

    // load dma to bank
    typedef struct packed {
        logic                       en;
        logic [BANK_ADDR_WIDTH-1:0] addr;
    } bank_rd_t;

    // array stream word, both directions
    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
    } strm_t;

endpackage

`default_nettype wire
